//--- vlog.f
hdl/axi_rd_pkg.sv
hdl/axi_burst_iter_ax.sv
hdl/axi_beat_mem.sv
hdl/axi_burst_rd_top.sv
dv/axi_burst_rd_assertions.sv
dv/axi_burst_rd_checker.sv
dv/axi_burst_rd_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert -j 0
TOP       ?= axi_burst_rd_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  := ALL TESTS PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
	  echo "test: pass"; \
	else \
	  echo "test: fail, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- dv/axi_burst_rd_tb.sv
module axi_burst_rd_tb;

  localparam int MEM_WORDS      = 256;
  localparam int idx_w          = $clog2(MEM_WORDS);
  localparam int timeout_cycles = 4000;
  localparam int n_rows         = 16;

  typedef struct packed {
    logic [axi_rd_pkg::id_w-1:0]   id;
    logic [axi_rd_pkg::addr_w-1:0] addr;
    logic [axi_rd_pkg::len_w-1:0]  len;
    logic [axi_rd_pkg::size_w-1:0] size;
    axi_rd_pkg::burst_e            burst;
    logic                          stall; // random r_ready while this burst drains
  } row_t;

  logic                          clk;
  logic                          rst_n;
  logic                          ar_valid;
  axi_rd_pkg::ax_req_t           ar;
  logic                          ar_ready;
  logic                          wr_en;
  logic [idx_w-1:0]              wr_addr;
  logic [axi_rd_pkg::data_w-1:0] wr_data;
  logic                          r_valid;
  axi_rd_pkg::r_beat_t           r;
  logic                          r_ready;

  row_t        rows [n_rows];
  logic [31:0] lfsr_q;
  int          timeouts;
  int          value_errors;
  int          proto_errors;
  int          assert_errors;
  int          total_errors;

  axi_burst_rd_top #(
    .MEM_WORDS (MEM_WORDS)
  ) i_axi_burst_rd_top (
    .clk      (clk),
    .rst_n    (rst_n),
    .ar_valid (ar_valid),
    .ar       (ar),
    .ar_ready (ar_ready),
    .wr_en    (wr_en),
    .wr_addr  (wr_addr),
    .wr_data  (wr_data),
    .r_valid  (r_valid),
    .r        (r),
    .r_ready  (r_ready)
  );

  axi_burst_rd_checker #(
    .MEM_WORDS (MEM_WORDS)
  ) i_checker (
    .clk          (clk),
    .rst_n        (rst_n),
    .ar_valid     (ar_valid),
    .ar           (ar),
    .ar_ready     (ar_ready),
    .wr_en        (wr_en),
    .wr_addr      (wr_addr),
    .wr_data      (wr_data),
    .r_valid      (r_valid),
    .r            (r),
    .r_ready      (r_ready),
    .value_errors (value_errors),
    .proto_errors (proto_errors)
  );

  always #5 clk = ~clk;

  // fibonacci lfsr with taps 32, 22, 2 and 1, one step per bit taken
  function automatic logic draw_bit();
    logic fb;
    fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
    lfsr_q = {lfsr_q[30:0], fb};
    return fb;
  endfunction

  task automatic fill_memory();
    logic [23:0] noise;
    for (int a = 0; a < MEM_WORDS; a++) begin
      for (int b = 0; b < 24; b++) begin
        noise = {noise[22:0], draw_bit()};
      end
      @(negedge clk);
      wr_en   = 1'b1;
      wr_addr = idx_w'(a);
      wr_data = {noise, 8'(a)}; // low byte is the word index so aliasing shows up
    end
    @(negedge clk);
    wr_en = 1'b0;
  endtask

  task automatic drive_requests();
    int unsigned waited;
    for (int i = 0; i < n_rows; i++) begin
      @(negedge clk);
      ar_valid = 1'b1;
      ar.id    = rows[i].id;
      ar.addr  = rows[i].addr;
      ar.len   = rows[i].len;
      ar.size  = rows[i].size;
      ar.burst = rows[i].burst;
      waited   = 0;
      while (!ar_ready && waited < timeout_cycles) begin
        @(negedge clk);
        waited++;
      end
      if (!ar_ready) begin
        $display("timeout: row %0d was not accepted on AR within %0d cycles", i, timeout_cycles);
        timeouts++;
        break;
      end
    end
    @(negedge clk);
    ar_valid = 1'b0;
  endtask

  task automatic collect_beats();
    int unsigned got;
    int unsigned need;
    int unsigned waited;
    for (int i = 0; i < n_rows && timeouts == 0; i++) begin
      need   = 32'(rows[i].len) + 1;
      got    = 0;
      waited = 0;
      while (got < need && waited < timeout_cycles) begin
        @(negedge clk);
        r_ready = rows[i].stall ? draw_bit() : 1'b1;
        if (r_valid && r_ready) begin
          got++; // transfers on the coming rising edge
        end
        waited++;
      end
      if (got < need) begin
        $display("timeout: row %0d returned only %0d of %0d R beats", i, got, need);
        timeouts++;
      end
    end
    @(negedge clk);
    r_ready = 1'b1;
  endtask

  initial begin
    clk      = 1'b0;
    rst_n    = 1'b0;
    ar_valid = 1'b0;
    ar       = '0;
    wr_en    = 1'b0;
    wr_addr  = '0;
    wr_data  = '0;
    r_ready  = 1'b1;
    lfsr_q   = 32'hd2f37b8b;
    timeouts = 0;
    rows = '{
      '{4'h1, 16'h0000, 8'd0,   3'd2, axi_rd_pkg::burst_incr,  1'b0},
      '{4'h2, 16'h0010, 8'd3,   3'd2, axi_rd_pkg::burst_incr,  1'b0},
      '{4'h3, 16'h0101, 8'd7,   3'd0, axi_rd_pkg::burst_incr,  1'b0},
      '{4'h4, 16'h0202, 8'd5,   3'd1, axi_rd_pkg::burst_incr,  1'b0},
      '{4'h5, 16'h0000, 8'd255, 3'd2, axi_rd_pkg::burst_incr,  1'b0},
      '{4'h6, 16'h0300, 8'd255, 3'd2, axi_rd_pkg::burst_incr,  1'b1},
      '{4'h7, 16'h0044, 8'd4,   3'd2, axi_rd_pkg::burst_fixed, 1'b0},
      '{4'h8, 16'h0081, 8'd2,   3'd0, axi_rd_pkg::burst_fixed, 1'b1},
      '{4'h9, 16'h0024, 8'd1,   3'd2, axi_rd_pkg::burst_wrap,  1'b0},
      '{4'ha, 16'h0038, 8'd3,   3'd2, axi_rd_pkg::burst_wrap,  1'b0},
      '{4'hb, 16'h0054, 8'd7,   3'd2, axi_rd_pkg::burst_wrap,  1'b0},
      '{4'hc, 16'h00a8, 8'd15,  3'd2, axi_rd_pkg::burst_wrap,  1'b0},
      '{4'hd, 16'h0136, 8'd7,   3'd1, axi_rd_pkg::burst_wrap,  1'b0},
      '{4'he, 16'h0207, 8'd15,  3'd0, axi_rd_pkg::burst_wrap,  1'b0},
      '{4'hf, 16'h03f0, 8'd15,  3'd2, axi_rd_pkg::burst_wrap,  1'b1},
      '{4'h0, 16'h0800, 8'd15,  3'd2, axi_rd_pkg::burst_incr,  1'b1}
    };
    repeat (4) @(negedge clk);
    rst_n = 1'b1;
    fill_memory();
    fork
      drive_requests();
      collect_beats();
    join
    repeat (2) @(negedge clk); // the checker sees the final beat on the edge in between
    assert_errors = i_axi_burst_rd_top.i_axi_burst_rd_assertions.fail_count;
    total_errors  = value_errors + proto_errors + assert_errors + timeouts;
    $display("errors: value %0d, protocol %0d, assertion %0d, timeout %0d",
             value_errors, proto_errors, assert_errors, timeouts);
    if (total_errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

//--- dv/axi_burst_rd_checker.sv
module axi_burst_rd_checker #(
  parameter int MEM_WORDS = 256
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          ar_valid,
  input  axi_rd_pkg::ax_req_t           ar,
  input  logic                          ar_ready,
  input  logic                          wr_en,
  input  logic [$clog2(MEM_WORDS)-1:0]  wr_addr,
  input  logic [axi_rd_pkg::data_w-1:0] wr_data,
  input  logic                          r_valid,
  input  axi_rd_pkg::r_beat_t           r,
  input  logic                          r_ready,
  output int                            value_errors,
  output int                            proto_errors
);

  localparam int idx_w = $clog2(MEM_WORDS);

  logic [axi_rd_pkg::data_w-1:0] mem_model [MEM_WORDS];
  axi_rd_pkg::r_beat_t           exp_q [$];
  int unsigned                   tag_q [$];   // burst number of each expected beat
  bit                            first_q [$];
  int unsigned                   cycle;
  int unsigned                   ar_cycle;
  int unsigned                   prev_r_cycle;
  int unsigned                   burst_cnt;
  bit                            clean;       // r_ready high at every edge since the latest AR
  bit                            check_reset;

  initial begin
    value_errors = 0;
    proto_errors = 0;
    cycle        = 0;
    burst_cnt    = 0;
    clean        = 1'b0;
    check_reset  = 1'b0;
  end

  // address of beat i from the AXI burst rules
  function automatic logic [axi_rd_pkg::addr_w-1:0] beat_addr(
    input axi_rd_pkg::ax_req_t req,
    input int unsigned         i
  );
    int unsigned start;
    int unsigned step;
    int unsigned win;
    int unsigned base;
    logic [axi_rd_pkg::addr_w-1:0] a;
    start = 32'(req.addr);
    step  = 32'd1 << req.size;
    win   = (32'(req.len) + 1) * step;
    base  = start - (start % win);
    case (req.burst)
      axi_rd_pkg::burst_fixed: a = req.addr;
      axi_rd_pkg::burst_wrap:  a = axi_rd_pkg::addr_w'(base + (start - base + i * step) % win);
      default:                 a = axi_rd_pkg::addr_w'(start + i * step);
    endcase
    return a;
  endfunction

  task automatic compare_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
    if (actual !== expected) begin
      $display("CHECK FAILED time=%0t signal=%s expected=%h got=%h",
               $time, name, expected, actual);
      value_errors++;
    end
  endtask

  always @(posedge clk) begin
    int unsigned         outstanding;
    int unsigned         n_beats;
    int unsigned         tag;
    bit                  first;
    axi_rd_pkg::r_beat_t exp;
    logic [axi_rd_pkg::addr_w-1:0] a;
    cycle++;
    if (!rst_n) begin
      exp_q.delete();
      tag_q.delete();
      first_q.delete();
      check_reset = 1'b1;
    end else begin
      if (check_reset) begin
        check_reset = 1'b0;
        compare_value("ar_ready", 32'd1, 32'(ar_ready));
        compare_value("r_valid", 32'd0, 32'(r_valid));
      end
      if (wr_en) begin
        mem_model[wr_addr] = wr_data;
      end
      if (!r_ready) begin
        clean = 1'b0;
      end
      outstanding = exp_q.size();
      if (r_valid && r_ready) begin
        if (outstanding == 0) begin
          $display("time %0t: R beat with id %0h arrived while no beat was expected",
                   $time, r.id);
          proto_errors++;
        end else begin
          exp   = exp_q.pop_front();
          tag   = tag_q.pop_front();
          first = first_q.pop_front();
          compare_value("r.id", 32'(exp.id), 32'(r.id));
          compare_value("r.data", exp.data, r.data);
          compare_value("r.last", 32'(exp.last), 32'(r.last));
          if (clean && tag == burst_cnt) begin
            if (first) begin
              compare_value("r latency after AR", 32'd2, cycle - ar_cycle);
            end else begin
              compare_value("r beat spacing", 32'd1, cycle - prev_r_cycle);
            end
          end
          prev_r_cycle = cycle;
        end
      end
      if (ar_valid && ar_ready) begin
        if (outstanding > 1) begin
          $display("time %0t: AR accepted while %0d beats of the previous burst were pending",
                   $time, outstanding);
          proto_errors++;
        end
        burst_cnt++;
        clean    = 1'b1;
        ar_cycle = cycle;
        n_beats  = 32'(ar.len) + 1;
        for (int unsigned i = 0; i < n_beats; i++) begin
          a        = beat_addr(ar, i);
          exp.id   = ar.id;
          exp.data = mem_model[idx_w'((32'(a) >> 2) % MEM_WORDS)];
          exp.last = (i == n_beats - 1);
          exp_q.push_back(exp);
          tag_q.push_back(burst_cnt);
          first_q.push_back(i == 0);
        end
      end
    end
  end

endmodule

//--- dv/axi_burst_rd_assertions.sv
module axi_burst_rd_assertions (
  input logic                clk,
  input logic                rst_n,
  input logic                ar_valid,
  input axi_rd_pkg::ax_req_t ar,
  input logic                ar_ready,
  input logic                r_valid,
  input axi_rd_pkg::r_beat_t r,
  input logic                r_ready
);

  int fail_count = 0; // read by the testbench at the end of the run

  reset_state: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(rst_n) |-> ar_ready && !r_valid)
    else begin
      $error("ar_ready or r_valid has the wrong value right after reset");
      fail_count++;
    end

  // a request on offer stays put until the iterator takes it
  ar_stable: assert property (@(posedge clk) disable iff (!rst_n)
    ar_valid && !ar_ready |=> ar_valid && $stable(ar))
    else begin
      $error("AR request changed or was withdrawn before it was accepted");
      fail_count++;
    end

  r_stable: assert property (@(posedge clk) disable iff (!rst_n)
    r_valid && !r_ready |=> r_valid && $stable(r))
    else begin
      $error("R beat changed or was withdrawn while r_ready was low");
      fail_count++;
    end

  // the last beat of a burst has not left the iterator yet
  ar_blocked: assert property (@(posedge clk) disable iff (!rst_n)
    r_valid && !r.last |-> !ar_ready)
    else begin
      $error("ar_ready was high while a burst still had beats to deliver");
      fail_count++;
    end

endmodule

bind axi_burst_rd_top axi_burst_rd_assertions i_axi_burst_rd_assertions (
  .clk      (clk),
  .rst_n    (rst_n),
  .ar_valid (ar_valid),
  .ar       (ar),
  .ar_ready (ar_ready),
  .r_valid  (r_valid),
  .r        (r),
  .r_ready  (r_ready)
);

//--- hdl/axi_burst_rd_top.sv
module axi_burst_rd_top #(
  parameter int MEM_WORDS = 256
) (
  input  logic                          clk,
  input  logic                          rst_n,

  input  logic                          ar_valid,
  input  axi_rd_pkg::ax_req_t           ar,
  output logic                          ar_ready,

  input  logic                          wr_en,
  input  logic [$clog2(MEM_WORDS)-1:0]  wr_addr,
  input  logic [axi_rd_pkg::data_w-1:0] wr_data,

  output logic                          r_valid,
  output axi_rd_pkg::r_beat_t           r,
  input  logic                          r_ready
);

  // internal beat channel between iterator and memory
  logic                beat_valid;
  axi_rd_pkg::ax_req_t beat;
  logic                beat_last;
  logic                beat_ready;

  axi_burst_iter_ax i_axi_burst_iter_ax (
    .clk        (clk),
    .rst_n      (rst_n),
    .ar_valid   (ar_valid),
    .ar         (ar),
    .ar_ready   (ar_ready),
    .beat_valid (beat_valid),
    .beat       (beat),
    .beat_last  (beat_last),
    .beat_ready (beat_ready)
  );

  axi_beat_mem #(
    .MEM_WORDS (MEM_WORDS)
  ) i_axi_beat_mem (
    .clk        (clk),
    .rst_n      (rst_n),
    .wr_en      (wr_en),
    .wr_addr    (wr_addr),
    .wr_data    (wr_data),
    .beat_valid (beat_valid),
    .beat       (beat),
    .beat_last  (beat_last),
    .beat_ready (beat_ready),
    .r_valid    (r_valid),
    .r          (r),
    .r_ready    (r_ready)
  );

endmodule

//--- hdl/axi_beat_mem.sv
module axi_beat_mem #(
  parameter int MEM_WORDS = 256
) (
  input  logic                          clk,
  input  logic                          rst_n,

  input  logic                          wr_en,
  input  logic [$clog2(MEM_WORDS)-1:0]  wr_addr,
  input  logic [axi_rd_pkg::data_w-1:0] wr_data,

  input  logic                          beat_valid,
  input  axi_rd_pkg::ax_req_t           beat,
  input  logic                          beat_last,
  output logic                          beat_ready,

  output logic                          r_valid,
  output axi_rd_pkg::r_beat_t           r,
  input  logic                          r_ready
);

  localparam int idx_w = $clog2(MEM_WORDS);

  logic [axi_rd_pkg::data_w-1:0] mem [MEM_WORDS];
  logic [axi_rd_pkg::addr_w-1:0] word_addr;
  logic [idx_w-1:0]              rd_idx;
  logic                          beat_fire;

  // each beat returns the whole aligned word, so only id and addr matter here
  assign word_addr = beat.addr >> axi_rd_pkg::word_shift;
  assign rd_idx    = idx_w'(word_addr % MEM_WORDS); // addresses alias past the top

  // take a new beat when the output register is empty or drains this cycle
  assign beat_ready = !r_valid || r_ready;
  assign beat_fire  = beat_valid && beat_ready;

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      r_valid <= 1'b0;
    end else if (beat_fire) begin
      r_valid <= 1'b1;
    end else if (r_ready) begin
      r_valid <= 1'b0;
    end
  end

  // r only changes on a new beat, so it holds while r_ready is low
  always_ff @(posedge clk) begin
    if (beat_fire) begin
      r.id   <= beat.id;
      r.data <= mem[rd_idx];
      r.last <= beat_last;
    end
  end

endmodule

//--- hdl/axi_burst_iter_ax.sv
module axi_burst_iter_ax (
  input  logic                clk,
  input  logic                rst_n,

  input  logic                ar_valid,
  input  axi_rd_pkg::ax_req_t ar,
  output logic                ar_ready,

  output logic                beat_valid,
  output axi_rd_pkg::ax_req_t beat,
  output logic                beat_last,
  input  logic                beat_ready
);

  axi_rd_pkg::iter_state_e       state_q;
  axi_rd_pkg::ax_req_t           req_q;     // accepted burst, addr keeps the start address
  logic [axi_rd_pkg::addr_w-1:0] addr_q;    // address of the beat on offer
  logic [axi_rd_pkg::len_w-1:0]  cnt_q;     // beats already sent
  logic [axi_rd_pkg::addr_w-1:0] step;
  logic [axi_rd_pkg::addr_w-1:0] wrap_mask;
  logic [axi_rd_pkg::addr_w-1:0] addr_inc;
  logic [axi_rd_pkg::addr_w-1:0] addr_next;
  logic                          ar_fire;
  logic                          beat_fire;

  assign ar_ready   = (state_q == axi_rd_pkg::st_idle);
  assign ar_fire    = ar_valid && ar_ready;
  assign beat_valid = (state_q == axi_rd_pkg::st_busy);
  assign beat_fire  = beat_valid && beat_ready;
  assign beat_last  = (cnt_q == req_q.len);

  // bytes per beat
  assign step = axi_rd_pkg::addr_w'(1) << req_q.size;

  // the wrap window is (len+1) beats wide and aligned to its own size
  assign wrap_mask = ((axi_rd_pkg::addr_w'(req_q.len) + axi_rd_pkg::addr_w'(1))
                      << req_q.size) - axi_rd_pkg::addr_w'(1);

  assign addr_inc = addr_q + step;

  always_comb begin
    case (req_q.burst)
      axi_rd_pkg::burst_fixed: begin
        addr_next = req_q.addr;
      end
      axi_rd_pkg::burst_wrap: begin
        addr_next = (addr_q & ~wrap_mask) | (addr_inc & wrap_mask); // low bits roll over
      end
      default: begin
        addr_next = addr_inc; // reserved encoding behaves as incr
      end
    endcase
  end

  // every beat is a single transfer at its own address
  always_comb begin
    beat.id    = req_q.id;
    beat.addr  = addr_q;
    beat.len   = '0;
    beat.size  = req_q.size;
    beat.burst = axi_rd_pkg::burst_fixed;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q <= axi_rd_pkg::st_idle;
      cnt_q   <= '0;
    end else begin
      case (state_q)
        axi_rd_pkg::st_idle: begin
          if (ar_fire) begin
            state_q <= axi_rd_pkg::st_busy;
            cnt_q   <= '0;
          end
        end
        axi_rd_pkg::st_busy: begin
          if (beat_fire) begin
            cnt_q <= cnt_q + 1'b1;
            if (beat_last) begin
              state_q <= axi_rd_pkg::st_idle; // ar_ready follows one cycle later
            end
          end
        end
        default: begin
          state_q <= axi_rd_pkg::st_idle;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (ar_fire) begin
      req_q  <= ar;
      addr_q <= ar.addr;
    end else if (beat_fire) begin
      addr_q <= addr_next;
    end
  end

endmodule

//--- hdl/axi_rd_pkg.sv
package axi_rd_pkg;

  localparam int addr_w     = 16;
  localparam int id_w       = 4;
  localparam int data_w     = 32;
  localparam int len_w      = 8;
  localparam int size_w     = 3;
  localparam int word_shift = 2; // byte address to word index

  // AXI burst encodings
  typedef enum logic [1:0] {
    burst_fixed = 2'd0,
    burst_incr  = 2'd1,
    burst_wrap  = 2'd2
  } burst_e;

  typedef enum logic {
    st_idle = 1'b0,
    st_busy = 1'b1
  } iter_state_e;

  // request on AR and on the internal beat channel
  typedef struct packed {
    logic [id_w-1:0]   id;
    logic [addr_w-1:0] addr;
    logic [len_w-1:0]  len;  // beats minus one
    logic [size_w-1:0] size; // log2 of bytes per beat
    burst_e            burst;
  } ax_req_t;

  typedef struct packed {
    logic [id_w-1:0]   id;
    logic [data_w-1:0] data;
    logic              last;
  } r_beat_t;

endpackage
